// ==== emu_pkg.sv ====
`default_nettype none

package emu_pkg;

	// block address space, interleaved over the lanes by its low bits.
	localparam int ADDR_W = 8;
	localparam int NUM_LANES = 4;
	localparam int LANE_W = 2;

	// per-lane storage.
	localparam int LANE_ENTRIES = 64;
	localparam int ENTRY_W = $clog2(LANE_ENTRIES);
	localparam int TAGS_PER_LANE = 8;
	localparam int TAG_PTR_W = $clog2(TAGS_PER_LANE);

	localparam int LAT_W = 5;
	localparam logic [LAT_W-1:0] HIT_LATENCY = 5'd1;

	typedef enum logic
	{
		OP_LOOKUP,
		OP_FILL
	} emu_op_e;

	typedef enum logic [1:0]
	{
		OUT_HIT,
		OUT_MISS,
		OUT_MISS_PENDING
	} emu_kind_e;

	typedef struct packed
	{
		emu_op_e op;
		logic [ADDR_W-1:0] addr;
	} emu_req_t;

	typedef struct packed
	{
		logic [ADDR_W-1:0] addr;
		emu_kind_e kind;
		logic [LAT_W-1:0] latency;
	} emu_out_t;

	// config side view of the latency tables.
	typedef struct packed
	{
		logic en;
		logic [LANE_W-1:0] lane;
		logic [ENTRY_W-1:0] idx;
		logic [LAT_W-1:0] latency;
	} tbl_wr_t;

	typedef struct packed
	{
		logic en;
		logic [LANE_W-1:0] lane;
		logic [ENTRY_W-1:0] idx;
	} tbl_rd_t;

endpackage

`default_nettype wire

// ==== axil_pkg.sv ====
`default_nettype none

package axil_pkg;

	// byte addresses reach past the 1 KiB table window, so out of range accesses exist.
	localparam int AXIL_ADDR_W = 12;
	localparam int AXIL_DATA_W = 32;
	localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

	typedef enum logic [1:0]
	{
		OKAY = 2'b00,
		SLVERR = 2'b10
	} axil_resp_e;

	typedef struct packed
	{
		logic [AXIL_ADDR_W-1:0] addr;
	} axil_aw_t;

	typedef struct packed
	{
		logic [AXIL_DATA_W-1:0] data;
		logic [AXIL_STRB_W-1:0] strb;
	} axil_w_t;

	typedef struct packed
	{
		logic [AXIL_ADDR_W-1:0] addr;
	} axil_ar_t;

	typedef struct packed
	{
		axil_resp_e resp;
	} axil_b_t;

	typedef struct packed
	{
		logic [AXIL_DATA_W-1:0] data;
		axil_resp_e resp;
	} axil_r_t;

endpackage

`default_nettype wire

// ==== axil_latency_cfg.sv ====
`default_nettype none

module axil_latency_cfg
	import emu_pkg::*;
	import axil_pkg::*;
(
	input  logic                            clk,
	input  logic                            resetb,
	input  axil_aw_t                        aw,
	input  logic                            awvalid,
	output logic                            awready,
	input  axil_w_t                         w,
	input  logic                            wvalid,
	output logic                            wready,
	output axil_b_t                         b,
	output logic                            bvalid,
	input  logic                            bready,
	input  axil_ar_t                        ar,
	input  logic                            arvalid,
	output logic                            arready,
	output axil_r_t                         r,
	output logic                            rvalid,
	input  logic                            rready,
	output tbl_wr_t                         tbl_wr,
	output tbl_rd_t                         tbl_rd,
	input  logic [NUM_LANES-1:0][LAT_W-1:0] tbl_rd_data
);
	typedef enum logic [1:0]
	{
		CFG_IDLE,
		CFG_WRITE_RESP,
		CFG_READ_WAIT,
		CFG_READ_RESP
	} cfg_state_e;

	cfg_state_e state;
	logic wr_go;
	logic rd_go;
	logic wr_err;
	logic rd_err;
	logic rd_err_q;
	logic [LANE_W-1:0] rd_lane_q;
	logic [ADDR_W-1:0] wr_blk;
	logic [ADDR_W-1:0] rd_blk;

	// a write with both halves present wins over a read.
	assign wr_go = (state == CFG_IDLE) && awvalid && wvalid;
	assign rd_go = (state == CFG_IDLE) && arvalid && !(awvalid && wvalid);
	assign awready = wr_go;
	assign wready = wr_go;
	assign arready = rd_go;

	assign wr_blk = aw.addr[ADDR_W+1:2];
	assign rd_blk = ar.addr[ADDR_W+1:2];
	assign wr_err = |aw.addr[AXIL_ADDR_W-1:ADDR_W+2];
	assign rd_err = |ar.addr[AXIL_ADDR_W-1:ADDR_W+2];

	// block address low bits pick the lane, the rest index its table.
	always_comb
	begin
		tbl_wr.en = wr_go && !wr_err && w.strb[0];
		tbl_wr.lane = wr_blk[LANE_W-1:0];
		tbl_wr.idx = wr_blk[ADDR_W-1:LANE_W];
		tbl_wr.latency = w.data[LAT_W-1:0];
		tbl_rd.en = rd_go && !rd_err;
		tbl_rd.lane = rd_blk[LANE_W-1:0];
		tbl_rd.idx = rd_blk[ADDR_W-1:LANE_W];
	end

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
		begin
			state <= CFG_IDLE;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			case (state)
				CFG_IDLE:
				begin
					if (wr_go)
					begin
						state <= CFG_WRITE_RESP;
						bvalid <= 1'b1;
					end
					else if (rd_go)
						state <= CFG_READ_WAIT;
				end
				CFG_WRITE_RESP:
				begin
					if (bready)
					begin
						state <= CFG_IDLE;
						bvalid <= 1'b0;
					end
				end
				// lane table data shows up this cycle.
				CFG_READ_WAIT:
				begin
					state <= CFG_READ_RESP;
					rvalid <= 1'b1;
				end
				CFG_READ_RESP:
				begin
					if (rready)
					begin
						state <= CFG_IDLE;
						rvalid <= 1'b0;
					end
				end
				default:
					state <= CFG_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_go)
			b.resp <= wr_err ? SLVERR : OKAY;
		if (rd_go)
		begin
			rd_lane_q <= rd_blk[LANE_W-1:0];
			rd_err_q <= rd_err;
		end
		if (state == CFG_READ_WAIT)
		begin
			r.resp <= rd_err_q ? SLVERR : OKAY;
			r.data <= rd_err_q ? '0 : AXIL_DATA_W'(tbl_rd_data[rd_lane_q]);
		end
	end

	assert property (@(posedge clk) disable iff (!resetb) !(bvalid && rvalid))
		else $error("config B and R responses valid together");

endmodule

`default_nettype wire

// ==== request_router.sv ====
`default_nettype none

module request_router
	import emu_pkg::*;
(
	input  emu_req_t                 req,
	input  logic                     req_valid,
	output logic                     req_ready,
	output emu_req_t [NUM_LANES-1:0] lane_req,
	output logic [NUM_LANES-1:0]     lane_req_valid,
	input  logic [NUM_LANES-1:0]     lane_req_ready
);
	logic [LANE_W-1:0] sel;

	// lanes are interleaved on the low address bits.
	assign sel = req.addr[LANE_W-1:0];

	assign req_ready = lane_req_ready[sel];

	// full address goes on, so outcomes carry it back out.
	always_comb
	begin
		for (int i = 0; i < NUM_LANES; i++)
		begin
			lane_req_valid[i] = req_valid && (sel == LANE_W'(i));
			lane_req[i] = lane_req_valid[i] ? req : '0;
		end
	end

endmodule

`default_nettype wire

// ==== emu_lane.sv ====
`default_nettype none

module emu_lane
	import emu_pkg::*;
(
	input  logic              clk,
	input  logic              resetb,
	input  logic [LANE_W-1:0] lane_id,
	input  emu_req_t          lane_req,
	input  logic              lane_req_valid,
	output logic              lane_req_ready,
	output emu_out_t          lane_out,
	output logic              lane_out_valid,
	input  logic              lane_out_ready,
	input  tbl_wr_t           tbl_wr,
	input  tbl_rd_t           tbl_rd,
	output logic [LAT_W-1:0]  tbl_rd_data
);
	logic [LAT_W-1:0] lat_ram [LANE_ENTRIES];
	logic [ADDR_W-1:0] tag_addr [TAGS_PER_LANE];
	logic [TAGS_PER_LANE-1:0] tag_valid;
	logic [TAG_PTR_W-1:0] tag_wp;
	logic [LANE_ENTRIES-1:0] pending;

	logic s1_valid;
	emu_req_t s1_req;
	logic [LAT_W-1:0] s1_lat;
	logic [ENTRY_W-1:0] req_idx;
	logic [ENTRY_W-1:0] s1_idx;
	logic accept;
	logic retire;
	logic is_fill;
	logic tag_hit;

	assign req_idx = lane_req.addr[ADDR_W-1:LANE_W];
	assign s1_idx = s1_req.addr[ADDR_W-1:LANE_W];
	assign is_fill = (s1_req.op == OP_FILL);

	// a fill retires at once, a lookup waits for its outcome to leave.
	assign retire = s1_valid && (is_fill || lane_out_ready);
	assign lane_req_ready = !s1_valid || retire;
	assign accept = lane_req_valid && lane_req_ready;

	// config port of the latency table.
	always_ff @(posedge clk)
	begin
		if (tbl_wr.en && (tbl_wr.lane == lane_id))
			lat_ram[tbl_wr.idx] <= tbl_wr.latency;
		if (tbl_rd.en && (tbl_rd.lane == lane_id))
			tbl_rd_data <= lat_ram[tbl_rd.idx];
	end

	// stage one: register the request along with its table latency.
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			s1_req <= lane_req;
			s1_lat <= lat_ram[req_idx];
		end
	end

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
			s1_valid <= 1'b0;
		else if (lane_req_ready)
			s1_valid <= lane_req_valid;
	end

	// stage two: evaluate against the tags and pending bits.
	always_comb
	begin
		tag_hit = 1'b0;
		for (int i = 0; i < TAGS_PER_LANE; i++)
		begin
			if (tag_valid[i] && (tag_addr[i] == s1_req.addr))
				tag_hit = 1'b1;
		end
	end

	always_comb
	begin
		lane_out.addr = s1_req.addr;
		if (tag_hit)
		begin
			lane_out.kind = OUT_HIT;
			lane_out.latency = HIT_LATENCY;
		end
		else if (pending[s1_idx])
		begin
			lane_out.kind = OUT_MISS_PENDING;
			lane_out.latency = s1_lat;
		end
		else
		begin
			lane_out.kind = OUT_MISS;
			lane_out.latency = s1_lat;
		end
	end

	assign lane_out_valid = s1_valid && !is_fill;

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
		begin
			pending <= '0;
			tag_valid <= '0;
			tag_wp <= '0;
		end
		else if (retire)
		begin
			if (is_fill)
			begin
				pending[s1_idx] <= 1'b0;
				tag_valid[tag_wp] <= 1'b1;
				tag_wp <= tag_wp + 1'b1;
			end
			else if (!tag_hit)
				pending[s1_idx] <= 1'b1;
		end
	end

	// round-robin replacement, duplicates allowed.
	always_ff @(posedge clk)
	begin
		if (retire && is_fill)
			tag_addr[tag_wp] <= s1_req.addr;
	end

	assert property (@(posedge clk) disable iff (!resetb)
		lane_out_valid && !lane_out_ready |=> lane_out_valid && $stable(lane_out))
		else $error("lane outcome changed while held");

endmodule

`default_nettype wire

// ==== outcome_merger.sv ====
`default_nettype none

module outcome_merger
	import emu_pkg::*;
(
	input  logic                     clk,
	input  logic                     resetb,
	input  emu_out_t [NUM_LANES-1:0] lane_out,
	input  logic [NUM_LANES-1:0]     lane_out_valid,
	output logic [NUM_LANES-1:0]     lane_out_ready,
	output emu_out_t                 out,
	output logic                     out_valid,
	input  logic                     out_ready
);
	logic [LANE_W-1:0] rr_ptr;
	logic [LANE_W-1:0] cand;
	logic [LANE_W-1:0] grant_idx;
	logic grant_any;
	logic load;

	// output register is free or draining this cycle.
	assign load = !out_valid || out_ready;

	// scan from the far end so the lane closest to rr_ptr wins.
	always_comb
	begin
		grant_any = 1'b0;
		grant_idx = rr_ptr;
		cand = rr_ptr;
		for (int k = NUM_LANES - 1; k >= 0; k--)
		begin
			cand = rr_ptr + LANE_W'(k);
			if (lane_out_valid[cand])
			begin
				grant_any = 1'b1;
				grant_idx = cand;
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < NUM_LANES; i++)
			lane_out_ready[i] = load && grant_any && (grant_idx == LANE_W'(i));
	end

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
		begin
			out_valid <= 1'b0;
			rr_ptr <= '0;
		end
		else if (load)
		begin
			out_valid <= grant_any;
			if (grant_any)
				rr_ptr <= grant_idx + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load && grant_any)
			out <= lane_out[grant_idx];
	end

endmodule

`default_nettype wire

// ==== lat_emu_top.sv ====
`default_nettype none

module lat_emu_top
	import emu_pkg::*;
	import axil_pkg::*;
(
	input  logic     clk,
	input  logic     resetb,
	input  emu_req_t req,
	input  logic     req_valid,
	output logic     req_ready,
	output emu_out_t out,
	output logic     out_valid,
	input  logic     out_ready,
	input  axil_aw_t aw,
	input  logic     awvalid,
	output logic     awready,
	input  axil_w_t  w,
	input  logic     wvalid,
	output logic     wready,
	output axil_b_t  b,
	output logic     bvalid,
	input  logic     bready,
	input  axil_ar_t ar,
	input  logic     arvalid,
	output logic     arready,
	output axil_r_t  r,
	output logic     rvalid,
	input  logic     rready
);
	emu_req_t [NUM_LANES-1:0] lane_req;
	logic [NUM_LANES-1:0] lane_req_valid;
	logic [NUM_LANES-1:0] lane_req_ready;
	emu_out_t [NUM_LANES-1:0] lane_out;
	logic [NUM_LANES-1:0] lane_out_valid;
	logic [NUM_LANES-1:0] lane_out_ready;
	tbl_wr_t tbl_wr;
	tbl_rd_t tbl_rd;
	logic [NUM_LANES-1:0][LAT_W-1:0] tbl_rd_data;

	axil_latency_cfg axil_latency_cfg_inst
	(
		.clk, .resetb,
		.aw, .awvalid, .awready,
		.w, .wvalid, .wready,
		.b, .bvalid, .bready,
		.ar, .arvalid, .arready,
		.r, .rvalid, .rready,
		.tbl_wr, .tbl_rd, .tbl_rd_data
	);

	request_router request_router_inst
	(
		.req, .req_valid, .req_ready,
		.lane_req, .lane_req_valid, .lane_req_ready
	);

	for (genvar g = 0; g < NUM_LANES; g++)
	begin : g_lane
		emu_lane emu_lane_inst
		(
			.clk, .resetb,
			.lane_id(LANE_W'(g)),
			.lane_req(lane_req[g]),
			.lane_req_valid(lane_req_valid[g]),
			.lane_req_ready(lane_req_ready[g]),
			.lane_out(lane_out[g]),
			.lane_out_valid(lane_out_valid[g]),
			.lane_out_ready(lane_out_ready[g]),
			.tbl_wr, .tbl_rd,
			.tbl_rd_data(tbl_rd_data[g])
		);
	end

	outcome_merger outcome_merger_inst
	(
		.clk, .resetb,
		.lane_out, .lane_out_valid, .lane_out_ready,
		.out, .out_valid, .out_ready
	);

endmodule

`default_nettype wire

// ==== tb_lat_emu.sv ====
`default_nettype none

module tb_lat_emu
	import emu_pkg::*;
	import axil_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 500;

	typedef struct
	{
		string name;
		emu_op_e op;
		logic [ADDR_W-1:0] addr;
		bit throttle;
		emu_kind_e kind;
	} stim_t;

	logic clk = 1'b0;
	logic resetb;
	emu_req_t req;
	logic req_valid;
	logic req_ready;
	emu_out_t out;
	logic out_valid;
	logic out_ready;
	axil_aw_t aw;
	logic awvalid;
	logic awready;
	axil_w_t w;
	logic wvalid;
	logic wready;
	axil_b_t b;
	logic bvalid;
	logic bready;
	axil_ar_t ar;
	logic arvalid;
	logic arready;
	axil_r_t r;
	logic rvalid;
	logic rready;

	stim_t stim [$];
	bit throttle;
	int n_tests;
	int n_errors;

	// reference model state.
	logic [LAT_W-1:0] lat_copy [2**ADDR_W];
	bit pend_m [2**ADDR_W];
	logic [ADDR_W-1:0] tag_m [NUM_LANES][$];
	emu_out_t exp_q [NUM_LANES][$];
	int exp_id [NUM_LANES][$];

	lat_emu_top lat_emu_top_inst (.*);

	always #2 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int expected_left();
		int n;
		n = 0;
		for (int i = 0; i < NUM_LANES; i++)
			n += exp_q[i].size();
		return n;
	endfunction

	task automatic abort_wait(input string what);
		$display("timeout while waiting for %s", what);
		$display("RESULT: FAIL");
		$finish;
	endtask

	task automatic report_plain(input string name, input bit ok, input string why);
		n_tests++;
		if (ok)
			$display("ok   %s", name);
		else
		begin
			n_errors++;
			$display("FAILED %s: %s", name, why);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		n_tests++;
		if (exp !== act)
		begin
			n_errors++;
			$display("** Error %s: expected %0h, actual %0h", name, exp, act);
		end
		else
			$display("ok   %s", name);
	endtask

	// all waits sample one ns after the falling edge, ahead of the rising edge.
	task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
		output axil_resp_e resp);
		int t;
		@(negedge clk);
		aw.addr = addr;
		w.data = data;
		w.strb = 4'hf;
		awvalid = 1'b1;
		wvalid = 1'b1;
		#1;
		t = 0;
		while (!(awready && wready) && t < TIMEOUT)
		begin
			@(negedge clk);
			#1;
			t++;
		end
		if (t >= TIMEOUT)
			abort_wait("the AXI4-Lite write address and data handshake");
		else
		begin
			@(negedge clk);
			awvalid = 1'b0;
			wvalid = 1'b0;
			bready = 1'b1;
			#1;
			t = 0;
			while (!bvalid && t < TIMEOUT)
			begin
				@(negedge clk);
				#1;
				t++;
			end
			if (t >= TIMEOUT)
				abort_wait("the AXI4-Lite write response");
			else
			begin
				resp = b.resp;
				@(negedge clk);
				bready = 1'b0;
			end
		end
	endtask

	task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr, output logic [31:0] data,
		output axil_resp_e resp);
		int t;
		@(negedge clk);
		ar.addr = addr;
		arvalid = 1'b1;
		#1;
		t = 0;
		while (!arready && t < TIMEOUT)
		begin
			@(negedge clk);
			#1;
			t++;
		end
		if (t >= TIMEOUT)
			abort_wait("the AXI4-Lite read address handshake");
		else
		begin
			@(negedge clk);
			arvalid = 1'b0;
			rready = 1'b1;
			#1;
			t = 0;
			while (!rvalid && t < TIMEOUT)
			begin
				@(negedge clk);
				#1;
				t++;
			end
			if (t >= TIMEOUT)
				abort_wait("the AXI4-Lite read response");
			else
			begin
				data = r.data;
				resp = r.resp;
				@(negedge clk);
				rready = 1'b0;
			end
		end
	endtask

	task automatic load_latencies();
		logic [31:0] rng;
		axil_resp_e resp;
		int bad;
		rng = 32'h1bbe;
		bad = 0;
		for (int a = 0; a < 2**ADDR_W; a++)
		begin
			rng = xorshift32(rng);
			// keep table latencies apart from the hit latency.
			lat_copy[a] = LAT_W'(32'd2 + (rng % 32'd30));
			axil_write(AXIL_ADDR_W'(a * 4), 32'(lat_copy[a]), resp);
			if (resp !== OKAY)
				bad++;
		end
		report_plain("cfg_load", bad == 0, $sformatf("%0d table writes were not OKAY", bad));
	endtask

	task automatic check_config();
		int blks [7] = '{0, 1, 2, 3, 85, 170, 255};
		logic [31:0] data;
		axil_resp_e resp;
		string name;
		foreach (blks[i])
		begin
			axil_read(AXIL_ADDR_W'(blks[i] * 4), data, resp);
			name = $sformatf("cfg_read_%02h", blks[i]);
			check_value({name, "_data"}, 32'(lat_copy[blks[i]]), data);
			check_value({name, "_resp"}, 32'(OKAY), 32'(resp));
		end
		axil_read(12'd1024, data, resp);
		check_value("cfg_read_oob_resp", 32'(SLVERR), 32'(resp));
		axil_write(12'd1024, 32'(~lat_copy[0]), resp);
		check_value("cfg_write_oob_resp", 32'(SLVERR), 32'(resp));
		axil_read(12'd0, data, resp);
		check_value("cfg_write_oob_no_effect", 32'(lat_copy[0]), data);
	endtask

	task automatic add_lookup(input string name, input logic [ADDR_W-1:0] addr, input bit thr,
		input emu_kind_e kind);
		stim_t s;
		s.name = name;
		s.op = OP_LOOKUP;
		s.addr = addr;
		s.throttle = thr;
		s.kind = kind;
		stim.push_back(s);
	endtask

	task automatic add_fill(input string name, input logic [ADDR_W-1:0] addr, input bit thr);
		add_lookup(name, addr, thr, OUT_HIT);
		stim[stim.size() - 1].op = OP_FILL;
	endtask

	task automatic build_table();
		add_fill("fill_only_80", 8'h80, 1'b0);
		add_fill("fill_only_83", 8'h83, 1'b0);
		add_lookup("lookup_first_miss", 8'h05, 1'b0, OUT_MISS);
		add_lookup("lookup_second_pending", 8'h05, 1'b0, OUT_MISS_PENDING);
		add_fill("fill_05", 8'h05, 1'b0);
		add_lookup("lookup_hit_after_fill", 8'h05, 1'b0, OUT_HIT);
		add_lookup("evict_first_lookup", 8'h02, 1'b0, OUT_MISS);
		// nine fills to lane 2, the ninth lands on the slot of the first.
		for (int k = 0; k < 9; k++)
			add_fill($sformatf("evict_fill_%0d", k), ADDR_W'(2 + 4 * k), 1'b0);
		add_lookup("evict_lookup_replaced", 8'h02, 1'b0, OUT_MISS);
		add_lookup("evict_lookup_kept", 8'h06, 1'b0, OUT_HIT);
		add_lookup("mix_10_miss", 8'h10, 1'b1, OUT_MISS);
		add_lookup("mix_11_miss", 8'h11, 1'b1, OUT_MISS);
		add_lookup("mix_12_hit", 8'h12, 1'b1, OUT_HIT);
		add_lookup("mix_13_miss", 8'h13, 1'b1, OUT_MISS);
		add_lookup("mix_10_pending", 8'h10, 1'b1, OUT_MISS_PENDING);
		add_lookup("mix_83_hit", 8'h83, 1'b1, OUT_HIT);
		add_lookup("mix_80_hit", 8'h80, 1'b1, OUT_HIT);
		add_lookup("mix_11_pending", 8'h11, 1'b1, OUT_MISS_PENDING);
		add_lookup("mix_05_hit", 8'h05, 1'b1, OUT_HIT);
		add_lookup("mix_13_pending", 8'h13, 1'b1, OUT_MISS_PENDING);
		add_lookup("mix_26_miss", 8'h26, 1'b1, OUT_MISS);
		add_fill("mix_fill_10", 8'h10, 1'b1);
		add_lookup("mix_10_hit", 8'h10, 1'b1, OUT_HIT);
		add_lookup("mix_33_miss", 8'h33, 1'b1, OUT_MISS);
		add_lookup("mix_ff_miss", 8'hff, 1'b1, OUT_MISS);
		add_lookup("mix_fe_miss", 8'hfe, 1'b1, OUT_MISS);
		add_lookup("mix_fd_miss", 8'hfd, 1'b1, OUT_MISS);
		add_lookup("mix_fc_miss", 8'hfc, 1'b1, OUT_MISS);
		add_lookup("mix_fc_pending", 8'hfc, 1'b1, OUT_MISS_PENDING);
		add_lookup("mix_22_hit", 8'h22, 1'b1, OUT_HIT);
		add_lookup("mix_26_pending", 8'h26, 1'b1, OUT_MISS_PENDING);
	endtask

	// applies one accepted request to the model, in acceptance order.
	task automatic model_accept(input int id);
		stim_t s;
		logic [LANE_W-1:0] lane;
		emu_out_t e;
		bit hit;
		s = stim[id];
		lane = s.addr[LANE_W-1:0];
		if (s.op == OP_FILL)
		begin
			pend_m[s.addr] = 1'b0;
			tag_m[lane].push_back(s.addr);
			if (tag_m[lane].size() > TAGS_PER_LANE)
				void'(tag_m[lane].pop_front());
		end
		else
		begin
			hit = 1'b0;
			for (int i = 0; i < tag_m[lane].size(); i++)
			begin
				if (tag_m[lane][i] == s.addr)
					hit = 1'b1;
			end
			e.addr = s.addr;
			if (hit)
			begin
				e.kind = OUT_HIT;
				e.latency = HIT_LATENCY;
			end
			else if (pend_m[s.addr])
			begin
				e.kind = OUT_MISS_PENDING;
				e.latency = lat_copy[s.addr];
			end
			else
			begin
				e.kind = OUT_MISS;
				e.latency = lat_copy[s.addr];
				pend_m[s.addr] = 1'b1;
			end
			if (e.kind != s.kind)
			begin
				n_errors++;
				$display("table entry %s lists kind %s but the model gives %s",
					s.name, s.kind.name(), e.kind.name());
			end
			exp_q[lane].push_back(e);
			exp_id[lane].push_back(id);
		end
	endtask

	task automatic send_req(input int id);
		int t;
		@(negedge clk);
		req.op = stim[id].op;
		req.addr = stim[id].addr;
		req_valid = 1'b1;
		#1;
		throttle = stim[id].throttle;
		t = 0;
		while (!req_ready && t < TIMEOUT)
		begin
			@(negedge clk);
			#1;
			t++;
		end
		if (t >= TIMEOUT)
			abort_wait($sformatf("req_ready for %s", stim[id].name));
		else
			model_accept(id);
	endtask

	task automatic run_entries(input int first, input int last);
		for (int i = first; i < last; i++)
			send_req(i);
		@(negedge clk);
		req_valid = 1'b0;
		#1;
		throttle = 1'b0;
	endtask

	task automatic check_outcome();
		logic [LANE_W-1:0] lane;
		emu_out_t e;
		int id;
		lane = out.addr[LANE_W-1:0];
		n_tests++;
		if (exp_q[lane].size() == 0)
		begin
			n_errors++;
			$display("outcome for address %02h arrived with nothing expected on lane %0d",
				out.addr, lane);
		end
		else
		begin
			e = exp_q[lane].pop_front();
			id = exp_id[lane].pop_front();
			if (out !== e)
			begin
				n_errors++;
				$display("** Error %s: expected %02h %s lat %0d, actual %02h %s lat %0d",
					stim[id].name, e.addr, e.kind.name(), e.latency,
					out.addr, out.kind.name(), out.latency);
			end
			else
				$display("ok   %s: %s lat %0d", stim[id].name, out.kind.name(), out.latency);
		end
	endtask

	// outcome monitor.
	initial
	begin
		forever
		begin
			@(negedge clk);
			#1;
			if (out_valid && out_ready)
				check_outcome();
		end
	end

	// out_ready, randomly throttled while the current entry asks for it.
	initial
	begin
		logic [31:0] rdy_rng;
		rdy_rng = 32'h1bbe;
		out_ready = 1'b1;
		forever
		begin
			@(negedge clk);
			if (throttle)
			begin
				rdy_rng = xorshift32(rdy_rng);
				out_ready = rdy_rng[11];
			end
			else
				out_ready = 1'b1;
		end
	end

	initial
	begin
		bit quiet;
		int t;
		resetb = 1'b0;
		req = '0;
		req_valid = 1'b0;
		aw = '0;
		awvalid = 1'b0;
		w = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		ar = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		throttle = 1'b0;
		n_tests = 0;
		n_errors = 0;

		quiet = 1'b1;
		repeat (7)
		begin
			@(negedge clk);
			#1;
			if (out_valid || bvalid || rvalid)
				quiet = 1'b0;
		end
		@(negedge clk);
		resetb = 1'b1;
		repeat (4)
		begin
			@(negedge clk);
			#1;
			if (out_valid || bvalid || rvalid)
				quiet = 1'b0;
		end
		report_plain("reset_quiet", quiet, "a valid output rose during or right after reset");

		load_latencies();
		check_config();
		build_table();

		run_entries(0, 2);
		quiet = 1'b1;
		repeat (6)
		begin
			@(negedge clk);
			#1;
			if (out_valid)
				quiet = 1'b0;
		end
		report_plain("fill_only_quiet", quiet, "out_valid rose for fill-only traffic");

		run_entries(2, stim.size());

		t = 0;
		@(negedge clk);
		while ((expected_left() != 0 || out_valid) && t < TIMEOUT)
		begin
			@(negedge clk);
			t++;
		end
		report_plain("drain_complete", t < TIMEOUT,
			"expected outcomes were still missing when the drain wait ran out");

		quiet = 1'b1;
		repeat (8)
		begin
			@(negedge clk);
			#1;
			if (out_valid)
				quiet = 1'b0;
		end
		report_plain("idle_quiet", quiet, "out_valid rose after all outcomes had left");

		$display("tests %0d, errors %0d", n_tests, n_errors);
		if (n_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
emu_pkg.sv
axil_pkg.sv
axil_latency_cfg.sv
request_router.sv
emu_lane.sv
outcome_merger.sv
lat_emu_top.sv
tb_lat_emu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the lat_emu testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_lat_emu \
	-Mdir obj_dir -o tb_lat_emu
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_lat_emu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
	echo "simulation log holds no result line"
	exit 1
fi
exit 0
